/* Makefile */
# Verilator build and run of the fetch unit testbench
TOP = fetch_unit_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and pass only if the log holds the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   print this list"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f fetch_unit.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* commit_pkg.sv */
/*
 * commit side types seen by the fetch unit; only tgt_pc matters to fetch
 */
`default_nettype none

package commit_pkg;

	// destination of a committed result
	// the order follows the register file of the core, tgt_pc last
	typedef enum logic [2:0] {
		tgt_none,
		tgt_acc,
		tgt_x,
		tgt_y,
		tgt_sp,
		tgt_sr,
		tgt_mem,
		tgt_pc
	} commit_tgt_t;

	// the value carried on a commit bus, wide enough for an address
	typedef logic [15:0] commit_data_t;

endpackage

`default_nettype wire

/* fetch_consts.svh */
/*
 * build constants for the fetch front end, 16-bit address space
 * FETCH_SLOTS and FETCH_WINDOW_BYTES go together: two slots of up to 3 bytes each
 */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// the 6502 reset vector sits at the top of memory
`define FETCH_RESET_PC 16'hFFFC

// predecode width and the byte window that covers it
`define FETCH_SLOTS 2
`define FETCH_WINDOW_BYTES 6

// fetch queue entries, must be a power of two
`define FQ_DEPTH 8

// entries in the decoder buffer, equal to the credits held after reset
`define DEC_CREDITS 4

// return stack entries, must be a power of two
`define RAS_DEPTH 8

`endif

/* fetch_pkg.sv */
/*
 * types of the fetch path; instruction bytes are stored opcode first, in bits 7:0
 */
`default_nettype none

package fetch_pkg;

	// 16-bit byte address, as on the 6502
	typedef logic [15:0] addr_t;

	// opcode in bits 7:0, operand bytes above it
	// bytes beyond the instruction length read as zero
	typedef logic [23:0] insn_t;

	// length in bytes, 1 to 3, zero is never produced
	typedef logic [1:0] insn_len_t;

	// ==============================
	// control transfer classes
	// ==============================
	// plain covers everything that does not move the fetch address
	typedef enum logic [2:0] {
		plain,
		branch,
		jmp,
		jsr,
		rts
	} insn_class_t;

endpackage

`default_nettype wire

/* fetch_queue.sv */
/*
 * the writer must respect space; slots are written in order starting at slot 0
 * dec_credit returns one credit per pulse and is never raised above the initial credit count
 */
`default_nettype none
`include "fetch_consts.svh"

module fetch_queue import fetch_pkg::*; (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic [`FETCH_SLOTS-1:0] wr_take,
	input  wire addr_t                   wr_pc   [0:`FETCH_SLOTS-1],
	input  wire insn_t                   wr_insn [0:`FETCH_SLOTS-1],
	input  wire insn_len_t               wr_len  [0:`FETCH_SLOTS-1],
	input  wire logic                    dec_credit,
	output logic [1:0]                   space,
	output logic                         dec_valid,
	output addr_t                        dec_pc,
	output insn_t                        dec_insn,
	output insn_len_t                    dec_len
);

	localparam int PTR_W = $clog2(`FQ_DEPTH);
	localparam int CNT_W = $clog2(`FQ_DEPTH + 1);
	localparam int CRD_W = $clog2(`DEC_CREDITS + 1);

	addr_t q_pc [0:`FQ_DEPTH-1];
	insn_t q_insn [0:`FQ_DEPTH-1];
	insn_len_t q_len [0:`FQ_DEPTH-1];

	logic [PTR_W-1:0] rd_ptr, wr_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] free;
	logic [CNT_W-1:0] n_wr;
	logic [CRD_W-1:0] credits;

	assign free = CNT_W'(`FQ_DEPTH) - count;
	assign space = (free >= CNT_W'(2)) ? 2'd2 : free[1:0];

	// entries arriving this cycle
	always_comb begin
		n_wr = '0;
		for (int i = 0; i < `FETCH_SLOTS; i++)
			n_wr = n_wr + CNT_W'(wr_take[i]);
	end

	// ==============================
	// decoder side
	// ==============================
	// a beat is sent only when the decoder has a free buffer entry
	assign dec_valid = (count != '0) && (credits != '0);
	assign dec_pc = q_pc[rd_ptr];
	assign dec_insn = q_insn[rd_ptr];
	assign dec_len = q_len[rd_ptr];

	// payload storage, taken slots pack into consecutive entries
	always_ff @(posedge clk) begin : write_port
		logic [PTR_W-1:0] idx;
		idx = wr_ptr;
		for (int i = 0; i < `FETCH_SLOTS; i++) begin
			if (wr_take[i]) begin
				q_pc[idx] <= wr_pc[i];
				q_insn[idx] <= wr_insn[i];
				q_len[idx] <= wr_len[i];
				idx = idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			credits <= CRD_W'(`DEC_CREDITS);
		end else begin
			wr_ptr <= wr_ptr + n_wr[PTR_W-1:0];
			rd_ptr <= rd_ptr + PTR_W'(dec_valid);
			count <= count + n_wr - CNT_W'(dec_valid);
			// each beat spends a credit and each returned pulse restores one
			credits <= credits + CRD_W'(dec_credit) - CRD_W'(dec_valid);
		end
	end

	// the program counter must stop fetch before the queue runs out of room
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		n_wr <= free)
		else $error("fetch queue written beyond its depth");

	// the decoder can never hand back more entries than it was sent
	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		credits <= CRD_W'(`DEC_CREDITS))
		else $error("decoder returned more credits than it holds");

endmodule

`default_nettype wire

/* fetch_unit.f */
+incdir+.
fetch_pkg.sv
commit_pkg.sv
predecode.sv
return_stack.sv
program_counter.sv
fetch_queue.sv
fetch_unit.sv
tb_clock.sv
fetch_unit_tb.sv

/* fetch_unit.sv */
/*
 * the instruction memory must answer win_data and win_hit in the same cycle as pc
 * the decoder must accept every dec_valid beat and return one dec_credit per freed entry
 */
`default_nettype none
`include "fetch_consts.svh"

module fetch_unit import fetch_pkg::*; import commit_pkg::*; (
	input  wire logic                             clk,
	input  wire logic                             rst,
	output addr_t                                 pc,
	input  wire logic [8*`FETCH_WINDOW_BYTES-1:0] win_data,
	input  wire logic                             win_hit,
	input  wire logic                             branch_miss,
	input  wire addr_t                            miss_pc,
	input  wire logic                             commit0_v,
	input  wire commit_tgt_t                      commit0_tgt,
	input  wire commit_data_t                     commit0_bus,
	input  wire logic                             commit1_v,
	input  wire commit_tgt_t                      commit1_tgt,
	input  wire commit_data_t                     commit1_bus,
	input  wire logic                             commit2_v,
	input  wire commit_tgt_t                      commit2_tgt,
	input  wire commit_data_t                     commit2_bus,
	output logic                                  dec_valid,
	output addr_t                                 dec_pc,
	output insn_t                                 dec_insn,
	output insn_len_t                             dec_len,
	input  wire logic                             dec_credit
);

	insn_len_t slot_len [0:`FETCH_SLOTS-1];
	insn_class_t slot_class [0:`FETCH_SLOTS-1];
	insn_t slot_insn [0:`FETCH_SLOTS-1];
	addr_t slot_tgt [0:`FETCH_SLOTS-1];
	logic [`FETCH_SLOTS-1:0] slot_take;
	addr_t wr_pc [0:`FETCH_SLOTS-1];
	logic [1:0] q_space;
	addr_t ra;
	logic ras_push, ras_pop;
	addr_t ras_push_addr;

	// queue entry addresses follow the slot lengths from pc
	for (genvar i = 0; i < `FETCH_SLOTS; i++) begin : g_wr_pc
		if (i == 0) begin : g_first
			assign wr_pc[i] = pc;
		end else begin : g_next
			assign wr_pc[i] = wr_pc[i-1] + addr_t'(slot_len[i-1]);
		end
	end

	// ==============================
	// fetch pipeline
	// ==============================
	predecode i_predecode (
		.win_data   (win_data),
		.pc         (pc),
		.slot_len   (slot_len),
		.slot_class (slot_class),
		.slot_insn  (slot_insn),
		.slot_tgt   (slot_tgt)
	);

	return_stack i_return_stack (
		.clk       (clk),
		.rst       (rst),
		.push      (ras_push),
		.push_addr (ras_push_addr),
		.pop       (ras_pop),
		.top       (ra)
	);

	program_counter i_program_counter (
		.clk           (clk),
		.rst           (rst),
		.slot_len      (slot_len),
		.slot_class    (slot_class),
		.slot_insn     (slot_insn),
		.slot_tgt      (slot_tgt),
		.ra            (ra),
		.win_hit       (win_hit),
		.q_space       (q_space),
		.branch_miss   (branch_miss),
		.miss_pc       (miss_pc),
		.commit0_v     (commit0_v),
		.commit0_tgt   (commit0_tgt),
		.commit0_bus   (commit0_bus),
		.commit1_v     (commit1_v),
		.commit1_tgt   (commit1_tgt),
		.commit1_bus   (commit1_bus),
		.commit2_v     (commit2_v),
		.commit2_tgt   (commit2_tgt),
		.commit2_bus   (commit2_bus),
		.pc            (pc),
		.slot_take     (slot_take),
		.ras_push      (ras_push),
		.ras_push_addr (ras_push_addr),
		.ras_pop       (ras_pop)
	);

	// kept slots go to the decoder through the credit-controlled queue
	fetch_queue i_fetch_queue (
		.clk        (clk),
		.rst        (rst),
		.wr_take    (slot_take),
		.wr_pc      (wr_pc),
		.wr_insn    (slot_insn),
		.wr_len     (slot_len),
		.dec_credit (dec_credit),
		.space      (q_space),
		.dec_valid  (dec_valid),
		.dec_pc     (dec_pc),
		.dec_insn   (dec_insn),
		.dec_len    (dec_len)
	);

endmodule

`default_nettype wire

/* fetch_unit_tb.sv */
/*
 * directed tests against a 64 KB byte memory and a decoder that returns credits
 * expected streams come from the predecode and static prediction rules
 */
`default_nettype none
`include "fetch_consts.svh"

module fetch_unit_tb import fetch_pkg::*; import commit_pkg::*; ();

	logic clk, rst;
	addr_t pc;
	logic [8*`FETCH_WINDOW_BYTES-1:0] win_data;
	logic win_hit, branch_miss;
	addr_t miss_pc;
	logic commit0_v, commit1_v, commit2_v;
	commit_tgt_t commit0_tgt, commit1_tgt, commit2_tgt;
	commit_data_t commit0_bus, commit1_bus, commit2_bus;
	logic dec_valid;
	addr_t dec_pc;
	insn_t dec_insn;
	insn_len_t dec_len;
	logic dec_credit = 1'b0;

	logic [7:0] mem [0:65535];
	// every decoder beat, in arrival order
	addr_t log_pc [$];
	insn_len_t log_len [$];
	insn_t log_insn [$];
	// addresses the current test expects on the decoder side
	addr_t exp_pc [$];
	logic credit_on;
	// credits the decoder still has to hand back
	int owed = 0;
	int errors, checks, tests;
	logic [31:0] lfsr;

	tb_clock i_clock (.clk(clk), .rst(rst));

	fetch_unit i_dut (
		.clk         (clk),
		.rst         (rst),
		.pc          (pc),
		.win_data    (win_data),
		.win_hit     (win_hit),
		.branch_miss (branch_miss),
		.miss_pc     (miss_pc),
		.commit0_v   (commit0_v),
		.commit0_tgt (commit0_tgt),
		.commit0_bus (commit0_bus),
		.commit1_v   (commit1_v),
		.commit1_tgt (commit1_tgt),
		.commit1_bus (commit1_bus),
		.commit2_v   (commit2_v),
		.commit2_tgt (commit2_tgt),
		.commit2_bus (commit2_bus),
		.dec_valid   (dec_valid),
		.dec_pc      (dec_pc),
		.dec_insn    (dec_insn),
		.dec_len     (dec_len),
		.dec_credit  (dec_credit)
	);

	// ==============================
	// memory and decoder models
	// ==============================
	// the window wraps at the top of the 16-bit space
	always_comb begin
		for (int b = 0; b < `FETCH_WINDOW_BYTES; b++)
			win_data[8*b +: 8] = mem[pc + addr_t'(b)];
	end

	// frees each entry at once, so one credit goes back per beat while allowed
	always @(posedge clk) begin : decoder_model
		logic give;
		if (dec_valid === 1'b1) begin
			log_pc.push_back(dec_pc);
			log_len.push_back(dec_len);
			log_insn.push_back(dec_insn);
			owed++;
		end
		give = credit_on && (owed > 0);
		if (give)
			owed--;
		#1;
		dec_credit = give;
	end

	// ==============================
	// reference rules and helpers
	// ==============================
	function automatic insn_class_t ref_kind(input logic [7:0] op);
		case (op)
			8'h4C: return jmp;
			8'h20: return jsr;
			8'h60: return rts;
			8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0: return branch;
			default: return plain;
		endcase
	endfunction

	function automatic insn_len_t ref_len(input logic [7:0] op);
		case (ref_kind(op))
			jmp, jsr: return 2'd3;
			rts: return 2'd1;
			branch: return 2'd2;
			default: return (op[1:0] == 2'b00) ? 2'd1 : (op[1:0] == 2'b01) ? 2'd2 : 2'd3;
		endcase
	endfunction

	// bytes past the instruction length read as zero
	function automatic insn_t ref_insn(input addr_t a);
		insn_len_t n;
		insn_t v;
		n = ref_len(mem[a]);
		v = {mem[a + 16'd2], mem[a + 16'd1], mem[a]};
		if (n == 2'd1)
			v[23:8] = '0;
		else if (n == 2'd2)
			v[23:16] = '0;
		return v;
	endfunction

	// galois LFSR, one step per bit handed out
	function automatic logic rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < 8; i++)
			v = {v[6:0], rand_bit()};
		return v;
	endfunction

	// random instructions that never transfer control, setting bit 0 turns a transfer plain
	task automatic build_plain_run(input addr_t start, input int n);
		addr_t a;
		logic [7:0] op;
		insn_len_t len;
		a = start;
		repeat (n) begin
			op = rand_byte();
			if (ref_kind(op) != plain)
				op = op | 8'h01;
			len = ref_len(op);
			mem[a] = op;
			for (int j = 1; j < 3; j++)
				if (j < len)
					mem[a + addr_t'(j)] = rand_byte();
			a = a + addr_t'(len);
		end
	endtask

	task automatic expect_sequential(input addr_t start, input int n);
		addr_t a;
		a = start;
		exp_pc.delete();
		repeat (n) begin
			exp_pc.push_back(a);
			a = a + addr_t'(ref_len(mem[a]));
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic wait_reset();
		int t;
		t = 0;
		do begin
			@(posedge clk);
			#2;
			t++;
		end while (rst && t < 10);
		if (rst) begin
			$display("error: reset still asserted after 10 cycles");
			errors++;
		end
	endtask

	task automatic wait_beats(input int n, input int limit);
		int t;
		t = 0;
		while (log_pc.size() < n && t < limit) begin
			step();
			t++;
		end
		if (log_pc.size() < n) begin
			$display("error: only %0d of %0d decoder beats within %0d cycles",
				log_pc.size(), n, limit);
			errors++;
		end
	endtask

	// stops fetch and lets the queue empty so the next test starts with a clean log
	task automatic drain_queue();
		int quiet;
		int t;
		win_hit = 1'b0;
		quiet = 0;
		t = 0;
		while (quiet < 6 && t < 200) begin
			step();
			quiet = dec_valid ? 0 : quiet + 1;
			t++;
		end
		if (quiet < 6) begin
			$display("error: fetch queue kept delivering for 200 cycles");
			errors++;
		end
		log_pc.delete();
		log_len.delete();
		log_insn.delete();
	endtask

	task automatic redirect_to(input addr_t a);
		branch_miss = 1'b1;
		miss_pc = a;
		win_hit = 1'b1;
		step();
		branch_miss = 1'b0;
		check("pc", pc, a);
	endtask

	task automatic compare_stream(input int n);
		if (log_pc.size() < n) begin
			$display("error: %0d decoder beats logged, %0d needed", log_pc.size(), n);
			errors++;
			return;
		end
		for (int i = 0; i < n; i++) begin
			check("dec_pc", log_pc[i], exp_pc[i]);
			check("dec_len", log_len[i], ref_len(mem[exp_pc[i]]));
			check("dec_insn", log_insn[i], ref_insn(exp_pc[i]));
		end
	endtask

	task automatic end_test(input string name, input int err0);
		tests++;
		if (errors == err0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err0);
	endtask

	// ==============================
	// directed tests
	// ==============================
	task automatic reset_and_plain_run();
		check("pc", pc, `FETCH_RESET_PC);
		check("dec_valid", dec_valid, 1'b0);
		expect_sequential(`FETCH_RESET_PC, 12);
		wait_beats(12, 100);
		compare_stream(12);
	endtask

	// forward beq at 0200 falls through, backward bne at 0204 loops to 0200
	task automatic branch_prediction();
		mem[16'h0200] = 8'hF0;
		mem[16'h0201] = 8'h04;
		mem[16'h0202] = 8'hA9;
		mem[16'h0203] = 8'h01;
		mem[16'h0204] = 8'hD0;
		mem[16'h0205] = 8'hFA;
		// shares a group with the loop branch and must never be delivered
		mem[16'h0206] = 8'h18;
		drain_queue();
		redirect_to(16'h0200);
		exp_pc = '{16'h0200, 16'h0202, 16'h0204, 16'h0200, 16'h0202, 16'h0204,
			16'h0200, 16'h0202, 16'h0204};
		wait_beats(9, 60);
		compare_stream(9);
	endtask

	// jsr 0500, then clc and rts back to 0403, which jumps to a jmp loop at 0410
	task automatic call_and_return();
		mem[16'h0400] = 8'h20;
		mem[16'h0401] = 8'h00;
		mem[16'h0402] = 8'h05;
		mem[16'h0403] = 8'h4C;
		mem[16'h0404] = 8'h10;
		mem[16'h0405] = 8'h04;
		mem[16'h0410] = 8'h4C;
		mem[16'h0411] = 8'h10;
		mem[16'h0412] = 8'h04;
		mem[16'h0500] = 8'h18;
		mem[16'h0501] = 8'h60;
		drain_queue();
		redirect_to(16'h0400);
		exp_pc = '{16'h0400, 16'h0500, 16'h0501, 16'h0403, 16'h0410, 16'h0410, 16'h0410};
		wait_beats(7, 60);
		compare_stream(7);
	endtask

	// commit0 writes the accumulator, so only commit1, commit2 and the miss compete
	task automatic redirect_priority();
		drain_queue();
		commit0_v = 1'b1;
		commit0_tgt = tgt_acc;
		commit0_bus = 16'h0A00;
		commit1_v = 1'b1;
		commit1_tgt = tgt_pc;
		commit1_bus = 16'h0800;
		commit2_v = 1'b1;
		commit2_tgt = tgt_pc;
		commit2_bus = 16'h0700;
		branch_miss = 1'b1;
		miss_pc = 16'h0900;
		win_hit = 1'b1;
		step();
		commit0_v = 1'b0;
		commit1_v = 1'b0;
		commit2_v = 1'b0;
		branch_miss = 1'b0;
		check("pc", pc, 16'h0700);
		expect_sequential(16'h0700, 6);
		wait_beats(6, 50);
		compare_stream(6);
		// commit0 beats the miss, while a non-pc write on commit2 is ignored
		drain_queue();
		commit0_v = 1'b1;
		commit0_tgt = tgt_pc;
		commit0_bus = 16'h0600;
		commit2_v = 1'b1;
		commit2_tgt = tgt_acc;
		commit2_bus = 16'h0A00;
		branch_miss = 1'b1;
		miss_pc = 16'h0900;
		win_hit = 1'b1;
		step();
		commit0_v = 1'b0;
		commit2_v = 1'b0;
		branch_miss = 1'b0;
		check("pc", pc, 16'h0600);
		expect_sequential(16'h0600, 4);
		wait_beats(4, 50);
		compare_stream(4);
		// a branch miss on its own
		drain_queue();
		redirect_to(16'h0900);
		expect_sequential(16'h0900, 6);
		wait_beats(6, 50);
		compare_stream(6);
	endtask

	task automatic credit_backpressure();
		addr_t held;
		drain_queue();
		credit_on = 1'b0;
		redirect_to(16'h0A00);
		expect_sequential(16'h0A00, 14);
		wait_beats(`DEC_CREDITS, 50);
		// long enough for the queue to fill and freeze fetch
		repeat (20) step();
		check("dec_valid beats", log_pc.size(), `DEC_CREDITS);
		held = pc;
		step();
		check("pc", pc, held);
		credit_on = 1'b1;
		wait_beats(14, 100);
		compare_stream(14);
	endtask

	task automatic fetch_miss_hold();
		drain_queue();
		redirect_to(16'h0B00);
		win_hit = 1'b0;
		repeat (8) begin
			step();
			check("pc", pc, 16'h0B00);
		end
		check("dec_valid beats", log_pc.size(), 0);
		win_hit = 1'b1;
		expect_sequential(16'h0B00, 8);
		wait_beats(8, 50);
		compare_stream(8);
	endtask

	initial begin
		int err0;
		lfsr = 32'h5859;
		win_hit = 1'b1;
		branch_miss = 1'b0;
		miss_pc = '0;
		commit0_v = 1'b0;
		commit0_tgt = tgt_none;
		commit0_bus = '0;
		commit1_v = 1'b0;
		commit1_tgt = tgt_none;
		commit1_bus = '0;
		commit2_v = 1'b0;
		commit2_tgt = tgt_none;
		commit2_bus = '0;
		credit_on = 1'b1;
		errors = 0;
		checks = 0;
		tests = 0;
		// odd bytes keep untouched memory free of transfers
		for (int a = 0; a < 65536; a++)
			mem[a] = (8'(a >> 8) ^ 8'(a)) | 8'h01;
		build_plain_run(`FETCH_RESET_PC, 12);
		wait_reset();

		err0 = errors;
		reset_and_plain_run();
		end_test("reset and plain run", err0);
		err0 = errors;
		branch_prediction();
		end_test("branch prediction", err0);
		err0 = errors;
		call_and_return();
		end_test("call and return", err0);
		err0 = errors;
		redirect_priority();
		end_test("redirect priority", err0);
		err0 = errors;
		credit_backpressure();
		end_test("credit backpressure", err0);
		err0 = errors;
		fetch_miss_hold();
		end_test("fetch miss hold", err0);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* predecode.sv */
/*
 * purely combinational; slot 1 is decoded even when slot 0 transfers control
 * rts targets are not computed here, the program counter takes them from the stack
 */
`default_nettype none
`include "fetch_consts.svh"

module predecode import fetch_pkg::*; (
	input  wire logic [8*`FETCH_WINDOW_BYTES-1:0] win_data,
	input  wire addr_t                            pc,
	output insn_len_t                             slot_len   [0:`FETCH_SLOTS-1],
	output insn_class_t                           slot_class [0:`FETCH_SLOTS-1],
	output insn_t                                 slot_insn  [0:`FETCH_SLOTS-1],
	output addr_t                                 slot_tgt   [0:`FETCH_SLOTS-1]
);

	// window bytes remaining from the start of each slot
	logic [8*`FETCH_WINDOW_BYTES-1:0] slot_raw [0:`FETCH_SLOTS-1];
	// address of the first byte of each slot
	addr_t slot_addr [0:`FETCH_SLOTS-1];

	// branches are the opcodes with a zero low nibble and an odd high nibble
	function automatic insn_class_t op_class(input logic [7:0] op);
		if (op[4:0] == 5'b10000)
			return branch;
		case (op)
			8'h4C: return jmp;
			8'h20: return jsr;
			8'h60: return rts;
			default: return plain;
		endcase
	endfunction

	// transfers have fixed lengths, everything else follows the low two bits
	function automatic insn_len_t op_len(input logic [7:0] op);
		case (op_class(op))
			branch: return 2'd2;
			jmp, jsr: return 2'd3;
			rts: return 2'd1;
			default: return (op[1:0] == 2'b00) ? 2'd1 : (op[1:0] == 2'b01) ? 2'd2 : 2'd3;
		endcase
	endfunction

	// clear the operand bytes that belong to the next instruction
	function automatic insn_t trim(input insn_t raw, input insn_len_t len);
		case (len)
			2'd1: return {16'h0000, raw[7:0]};
			2'd2: return {8'h00, raw[15:0]};
			default: return raw;
		endcase
	endfunction

	// ==============================
	// per slot decode
	// ==============================
	for (genvar i = 0; i < `FETCH_SLOTS; i++) begin : g_slot
		if (i == 0) begin : g_first
			assign slot_raw[i] = win_data;
			assign slot_addr[i] = pc;
		end else begin : g_next
			// each slot begins right after the bytes of the one before it
			assign slot_raw[i] = slot_raw[i-1] >> {slot_len[i-1], 3'b000};
			assign slot_addr[i] = slot_addr[i-1] + addr_t'(slot_len[i-1]);
		end

		assign slot_class[i] = op_class(slot_raw[i][7:0]);
		assign slot_len[i] = op_len(slot_raw[i][7:0]);
		assign slot_insn[i] = trim(slot_raw[i][23:0], slot_len[i]);

		always_comb begin
			case (slot_class[i])
				// displacement is relative to the byte after the branch
				branch: slot_tgt[i] = slot_addr[i] + 16'd2
					+ {{8{slot_insn[i][15]}}, slot_insn[i][15:8]};
				// absolute target, low byte first
				jmp, jsr: slot_tgt[i] = slot_insn[i][23:8];
				// other classes report their fall-through address
				default: slot_tgt[i] = slot_addr[i] + addr_t'(slot_len[i]);
			endcase
		end
	end

endmodule

`default_nettype wire

/* program_counter.sv */
/*
 * q_space must count free fetch queue entries, capped at 2
 * a redirect discards the whole fetch group of that cycle
 */
`default_nettype none
`include "fetch_consts.svh"

module program_counter import fetch_pkg::*; import commit_pkg::*; (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire insn_len_t               slot_len   [0:`FETCH_SLOTS-1],
	input  wire insn_class_t             slot_class [0:`FETCH_SLOTS-1],
	input  wire insn_t                   slot_insn  [0:`FETCH_SLOTS-1],
	input  wire addr_t                   slot_tgt   [0:`FETCH_SLOTS-1],
	input  wire addr_t                   ra,
	input  wire logic                    win_hit,
	input  wire logic [1:0]              q_space,
	input  wire logic                    branch_miss,
	input  wire addr_t                   miss_pc,
	input  wire logic                    commit0_v,
	input  wire commit_tgt_t             commit0_tgt,
	input  wire commit_data_t            commit0_bus,
	input  wire logic                    commit1_v,
	input  wire commit_tgt_t             commit1_tgt,
	input  wire commit_data_t            commit1_bus,
	input  wire logic                    commit2_v,
	input  wire commit_tgt_t             commit2_tgt,
	input  wire commit_data_t            commit2_bus,
	output addr_t                        pc,
	output logic [`FETCH_SLOTS-1:0]      slot_take,
	output logic                         ras_push,
	output addr_t                        ras_push_addr,
	output logic                         ras_pop
);

	// commit writes aimed at the program counter
	logic c0_pc, c1_pc, c2_pc;
	logic redirect;
	logic freeze;
	// slot moves control elsewhere under the static prediction
	logic [`FETCH_SLOTS-1:0] taken;
	addr_t slot_addr [0:`FETCH_SLOTS-1];
	// predicted destination of each slot, with rts resolved from the stack
	addr_t slot_dest [0:`FETCH_SLOTS-1];
	addr_t next_pc;

	assign c0_pc = commit0_v && (commit0_tgt == tgt_pc);
	assign c1_pc = commit1_v && (commit1_tgt == tgt_pc);
	assign c2_pc = commit2_v && (commit2_tgt == tgt_pc);
	assign redirect = c0_pc || c1_pc || c2_pc || branch_miss;

	// the queue must be able to take a full group before fetch moves on
	assign freeze = !win_hit || (q_space < 2'd2);

	// ==============================
	// slot prediction
	// ==============================
	for (genvar i = 0; i < `FETCH_SLOTS; i++) begin : g_slot
		if (i == 0) begin : g_first
			assign slot_addr[i] = pc;
			assign slot_take[i] = !freeze && !redirect;
		end else begin : g_next
			assign slot_addr[i] = slot_addr[i-1] + addr_t'(slot_len[i-1]);
			// nothing after a taken transfer is kept
			assign slot_take[i] = slot_take[i-1] && !taken[i-1];
		end

		// backward branches are predicted taken, the sign sits in bit 15
		assign taken[i] = (slot_class[i] == jmp) || (slot_class[i] == jsr)
			|| (slot_class[i] == rts)
			|| ((slot_class[i] == branch) && slot_insn[i][15]);
		assign slot_dest[i] = (slot_class[i] == rts) ? ra : slot_tgt[i];
	end

	// ==============================
	// next fetch address
	// ==============================
	// later assignments win, so the code runs from lowest to highest priority
	always_comb begin
		// sequential case, past the last slot of the group
		next_pc = slot_addr[`FETCH_SLOTS-1] + addr_t'(slot_len[`FETCH_SLOTS-1]);
		// walk backwards so the first taken slot is the one left standing
		for (int i = `FETCH_SLOTS - 1; i >= 0; i--) begin
			if (taken[i])
				next_pc = slot_dest[i];
		end
		if (freeze)
			next_pc = pc;
		if (branch_miss)
			next_pc = miss_pc;
		// commit2 is the youngest commit and overrides the others
		if (c0_pc)
			next_pc = commit0_bus;
		if (c1_pc)
			next_pc = commit1_bus;
		if (c2_pc)
			next_pc = commit2_bus;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= `FETCH_RESET_PC;
		else
			pc <= next_pc;
	end

	// return stack updates come only from slots that are kept
	always_comb begin
		ras_push = 1'b0;
		ras_pop = 1'b0;
		ras_push_addr = pc + 16'd3;
		for (int i = 0; i < `FETCH_SLOTS; i++) begin
			if (slot_take[i] && (slot_class[i] == jsr)) begin
				ras_push = 1'b1;
				// return lands on the byte after the 3-byte jsr
				ras_push_addr = slot_addr[i] + 16'd3;
			end
			if (slot_take[i] && (slot_class[i] == rts))
				ras_pop = 1'b1;
		end
	end

	// a window miss or a queue without room for two entries, with no redirect on
	// the miss or commit ports, leaves the fetch address where it was
	a_freeze_holds_pc: assert property (@(posedge clk) disable iff (rst)
		((!win_hit || (q_space < 2'd2)) && !branch_miss
			&& !(commit0_v && (commit0_tgt == tgt_pc))
			&& !(commit1_v && (commit1_tgt == tgt_pc))
			&& !(commit2_v && (commit2_tgt == tgt_pc)))
		|=> (pc == $past(pc)))
		else $error("pc moved while fetch was frozen");

endmodule

`default_nettype wire

/* return_stack.sv */
/*
 * no underflow or overflow detection; overflow overwrites the oldest entry
 * top is undefined until the first push, and the stack is not repaired after a miss
 */
`default_nettype none
`include "fetch_consts.svh"

module return_stack import fetch_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  push,
	input  wire addr_t push_addr,
	input  wire logic  pop,
	output addr_t      top
);

	localparam int PTR_W = $clog2(`RAS_DEPTH);

	addr_t stack [0:`RAS_DEPTH-1];
	// points at the current top entry and wraps in both directions
	logic [PTR_W-1:0] sp;

	assign top = stack[sp];

	// entry storage
	always_ff @(posedge clk) begin
		// a push with a pop replaces the top in place
		if (push && pop)
			stack[sp] <= push_addr;
		else if (push)
			stack[sp + 1'b1] <= push_addr;
	end

	// pointer moves only when push and pop do not cancel
	always_ff @(posedge clk) begin
		if (rst)
			sp <= '0;
		else if (push && !pop)
			sp <= sp + 1'b1;
		else if (pop && !push)
			sp <= sp - 1'b1;
	end

	// the program counter keeps only the first taken transfer of a group, so a
	// push and a pop together would mean two slots reached the stack at once
	a_one_slot_per_cycle: assert property (@(posedge clk) disable iff (rst)
		!(push && pop))
		else $error("return stack pushed and popped in the same cycle");

endmodule

`default_nettype wire

/* tb_clock.sv */
/*
 * free-running clock of period 10, reset held over the first two rising edges
 */
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// released one time unit after the second rising edge
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
	end

endmodule

`default_nettype wire
